// ==== Bender.yml ====
package:
  name: fetch_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/cpu_bus_pkg.sv
      - logic/fetch_pkg.sv
      - logic/imem_if.sv
      - logic/pc_gen.sv
      - logic/fetch_ctrl.sv
      - logic/fetch_watchdog.sv
      - logic/if_stage.sv
      - logic/fetch_unit.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/fetch_unit_chk.sv
      - sim/fetch_unit_tb.sv

// ==== include/fetch_defines.svh ====
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// fetch address and pc width.
`define ADDR_W 64

// instruction memory beat width, two instructions per beat.
`define BEAT_W 64

// one uncompressed instruction.
`define INS_W 32

// boot address of the core.
`define RESET_PC 64'h0000_0000_8000_0000

// wait cycles allowed between req and r_valid.
`define FETCH_TIMEOUT 16

// watchdog counter width, holds FETCH_TIMEOUT plus one.
`define WDOG_W 5

`endif

// ==== logic/cpu_bus_pkg.sv ====
`include "fetch_defines.svh"

package cpu_bus_pkg;

	// response code returned with each memory beat.
	typedef enum logic [1:0] {
		okay   = 2'b00,	// normal access done.
		exokay = 2'b01,	// exclusive access done.
		slverr = 2'b10,	// slave reported an error.
		decerr = 2'b11	// no slave at this address.
	} mem_resp_e;

	// a beat holds two instructions, hi at the odd word.
	typedef struct packed {
		logic [`INS_W-1:0] hi;	// address bit 2 set.
		logic [`INS_W-1:0] lo;	// address bit 2 clear.
	} ins_pair_t;

	// one beat, seen raw on the bus or split into halves.
	typedef union packed {
		logic [`BEAT_W-1:0] raw;
		ins_pair_t          half;
	} fetch_beat_u;

endpackage

// ==== logic/fetch_ctrl.sv ====
`timescale 1ns/10ps
`include "fetch_defines.svh"

module fetch_ctrl (
	input  logic                clk,
	input  logic                reset,
	input  logic                id_ready,
	input  fetch_pkg::redirect_e redirect,
	imem_if.ctrl                bus,
	input  logic [`ADDR_W-1:0]  pc,
	input  logic                timeout,
	output logic                advance,
	output logic                take_redirect,
	output logic                capture,
	output logic                bubble,
	output logic                wait_active,
	output logic                fault
);
	import fetch_pkg::*;
	import cpu_bus_pkg::*;

	fetch_state_e state;
	fetch_state_e state_nxt;
	logic         redir_any;
	logic         resp_ok;

	assign redir_any = (redirect != none);
	assign resp_ok   = (bus.resp == okay) || (bus.resp == exokay);

	// the pc only moves on advance or redirect, so it is the beat address.
	assign bus.addr = pc;

	always_comb begin
		state_nxt     = state;
		bus.req       = 1'b0;
		capture       = 1'b0;
		advance       = 1'b0;
		take_redirect = (redirect == branch) || (redirect == trap);
		bubble        = redir_any;	// every redirect inserts a bubble.
		case (state)
			s_req: begin
				if (!reset && !redir_any && id_ready) begin
					bus.req   = 1'b1;	// one request, one beat.
					state_nxt = s_wait;
				end
			end
			s_wait: begin
				if (redir_any) begin
					state_nxt = s_req;	// in-flight beat is dropped.
				end else if (timeout) begin
					state_nxt = s_fault;
				end else if (bus.r_valid) begin
					if (resp_ok) begin
						capture   = 1'b1;
						advance   = 1'b1;
						state_nxt = s_req;
					end else begin
						state_nxt = s_fault;	// error beat is not captured.
					end
				end
			end
			s_fault: begin
				// only a trap gets the front end going again
				if (redirect == trap) begin
					state_nxt = s_req;
				end
			end
			default: begin
				state_nxt = s_req;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_req;
		end else begin
			state <= state_nxt;
		end
	end

	assign wait_active = (state == s_wait);	// watchdog runs here.
	assign fault       = (state == s_fault);

endmodule

// ==== logic/fetch_pkg.sv ====
package fetch_pkg;

	// fetch controller states.
	typedef enum logic [1:0] {
		s_req   = 2'b00,	// ready to issue the next request.
		s_wait  = 2'b01,	// one request in flight.
		s_fault = 2'b10	// stuck until a trap redirect.
	} fetch_state_e;

	// redirect request from later pipeline stages.
	typedef enum logic [1:0] {
		none       = 2'b00,	// nothing to do.
		branch     = 2'b01,	// taken branch or jump, load target.
		flush_only = 2'b10,	// drop the in-flight beat, keep pc.
		trap       = 2'b11	// load target and clear a fault.
	} redirect_e;

	// a trap behaves like a branch for the pc, it only differs
	// in that it is the one redirect that leaves s_fault.

endpackage

// ==== logic/fetch_unit.sv ====
`timescale 1ns/10ps
`include "fetch_defines.svh"

module fetch_unit (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  id_ready,
	input  fetch_pkg::redirect_e  redirect,
	input  logic [`ADDR_W-1:0]    redirect_pc,
	output logic                  mem_req,
	output logic [`ADDR_W-1:0]    mem_addr,
	input  logic                  mem_r_valid,
	input  logic [`BEAT_W-1:0]    mem_r_data,
	input  logic [`ADDR_W-1:0]    mem_r_addr,
	input  cpu_bus_pkg::mem_resp_e mem_resp,
	output logic                  id_valid,
	output logic [`ADDR_W-1:0]    id_pc,
	output logic [`INS_W-1:0]     id_ins,
	output logic [`ADDR_W-1:0]    id_snpc,
	output logic                  fault
);

	logic [`ADDR_W-1:0] pc;
	logic               advance;
	logic               take_redirect;
	logic               capture;
	logic               bubble;
	logic               wait_active;
	logic               timeout;

	imem_if imem_bus ();

	// memory response side comes in on plain ports.
	assign imem_bus.r_valid = mem_r_valid;
	assign imem_bus.r_data  = mem_r_data;
	assign imem_bus.r_addr  = mem_r_addr;
	assign imem_bus.resp    = mem_resp;

	assign mem_req  = imem_bus.req;
	assign mem_addr = imem_bus.addr;

	pc_gen pc_gen_i (
		.clk           (clk),
		.reset         (reset),
		.advance       (advance),
		.take_redirect (take_redirect),
		.redirect_pc   (redirect_pc),
		.pc            (pc)
	);

	fetch_ctrl fetch_ctrl_i (
		.clk           (clk),
		.reset         (reset),
		.id_ready      (id_ready),
		.redirect      (redirect),
		.bus           (imem_bus.ctrl),
		.pc            (pc),
		.timeout       (timeout),
		.advance       (advance),
		.take_redirect (take_redirect),
		.capture       (capture),
		.bubble        (bubble),
		.wait_active   (wait_active),
		.fault         (fault)
	);

	fetch_watchdog fetch_watchdog_i (
		.clk         (clk),
		.reset       (reset),
		.wait_active (wait_active),
		.timeout     (timeout)
	);

	if_stage if_stage_i (
		.clk      (clk),
		.reset    (reset),
		.capture  (capture),
		.bubble   (bubble),
		.pc       (pc),	// stable while the beat is in flight.
		.bus      (imem_bus.stage),
		.id_valid (id_valid),
		.id_pc    (id_pc),
		.id_ins   (id_ins),
		.id_snpc  (id_snpc)
	);

endmodule

// ==== logic/fetch_watchdog.sv ====
`timescale 1ns/10ps
`include "fetch_defines.svh"

module fetch_watchdog (
	input  logic clk,
	input  logic reset,
	input  logic wait_active,
	output logic timeout
);

	logic [`WDOG_W-1:0] wait_cnt;
	logic               cnt_sat;

	// stop one past the limit so timeout fires once per wait.
	assign cnt_sat = (wait_cnt == `WDOG_W'(`FETCH_TIMEOUT + 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			wait_cnt <= '0;
		end else if (!wait_active) begin
			wait_cnt <= '0;	// no request waiting.
		end else if (!cnt_sat) begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	// high in the cycle after the last allowed response cycle.
	assign timeout = wait_active && (wait_cnt == `WDOG_W'(`FETCH_TIMEOUT));

endmodule

// ==== logic/if_stage.sv ====
`timescale 1ns/10ps
`include "fetch_defines.svh"

module if_stage (
	input  logic               clk,
	input  logic               reset,
	input  logic               capture,
	input  logic               bubble,
	input  logic [`ADDR_W-1:0] pc,
	imem_if.stage              bus,
	output logic               id_valid,
	output logic [`ADDR_W-1:0] id_pc,
	output logic [`INS_W-1:0]  id_ins,
	output logic [`ADDR_W-1:0] id_snpc
);
	import cpu_bus_pkg::*;

	fetch_beat_u       beat;
	logic [`INS_W-1:0] ins_sel;
	logic              take;

	// capture only counts together with the memory strobe.
	assign take = capture && bus.r_valid;

	always_comb begin
		beat.raw = bus.r_data;
		if (bus.r_addr[2]) begin
			ins_sel = beat.half.hi;	// odd word of the beat.
		end else begin
			ins_sel = beat.half.lo;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			id_valid <= 1'b0;
		end else if (bubble || take) begin
			id_valid <= 1'b1;	// a bubble is a valid nop slot.
		end
	end

	always_ff @(posedge clk) begin
		if (bubble) begin
			id_pc   <= pc;	// old pc, target not loaded yet.
			id_ins  <= '0;
			id_snpc <= pc + `ADDR_W'd4;
		end else if (take) begin
			id_pc   <= pc;
			id_ins  <= ins_sel;
			id_snpc <= pc + `ADDR_W'd4;
		end
	end

endmodule

// ==== logic/imem_if.sv ====
`timescale 1ns/10ps
`include "fetch_defines.svh"

interface imem_if;
	import cpu_bus_pkg::*;

	logic              req;	// one-cycle request pulse.
	logic [`ADDR_W-1:0] addr;	// fetch address, valid with req.
	logic              r_valid;	// one-cycle response strobe.
	logic [`BEAT_W-1:0] r_data;	// returned beat.
	logic [`ADDR_W-1:0] r_addr;	// address the beat belongs to.
	mem_resp_e         resp;	// response code.

	// request side and the response status.
	modport ctrl (
		output req,
		output addr,
		input  r_valid,
		input  resp
	);

	// data path into the fetch/decode register.
	modport stage (
		input r_valid,
		input r_data,
		input r_addr
	);

endinterface

// ==== logic/pc_gen.sv ====
`timescale 1ns/10ps
`include "fetch_defines.svh"

module pc_gen (
	input  logic               clk,
	input  logic               reset,
	input  logic               advance,
	input  logic               take_redirect,
	input  logic [`ADDR_W-1:0] redirect_pc,
	output logic [`ADDR_W-1:0] pc
);

	logic [`ADDR_W-1:0] pc_seq;

	// next sequential instruction, no compressed forms.
	assign pc_seq = pc + `ADDR_W'd4;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `RESET_PC;	// boot address.
		end else if (take_redirect) begin
			pc <= redirect_pc;	// redirect wins over advance.
		end else if (advance) begin
			pc <= pc_seq;	// beat accepted, step on.
		end
	end

endmodule

// ==== sim/fetch_golden.txt ====
# addr lat resp beat rcyc kind target rdy_low, then expected id_pc id_ins id_snpc fault
# lat, rcyc and rdy_low decimal, rest hex; addr 0 is a redirect only, lat 99 is no answer
80000000 3 0 1111111100000013 0 0 00000000 0 80000000 00000013 80000004 0
80000004 1 1 aaaa0293bbbb0313 0 0 00000000 3 80000004 aaaa0293 80000008 0
80000008 5 0 00c5853300b50593 0 0 00000000 0 80000008 00b50593 8000000c 0
8000000c 16 0 40b50633fe0718e3 0 0 00000000 0 8000000c 40b50633 80000010 0
80000010 2 0 0000006f00000067 2 1 80000100 0 80000010 00000000 80000014 0
80000100 2 0 123456789abcdef0 0 0 00000000 0 80000100 9abcdef0 80000104 0
80000104 99 0 0000000000000000 3 2 00000000 0 80000104 00000000 80000108 0
80000104 1 0 0badc0dedeadbeef 0 0 00000000 0 80000104 0badc0de 80000108 0
80000108 2 2 ffffffffffffffff 0 0 00000000 0 80000104 0badc0de 80000108 1
00000000 0 0 0000000000000000 0 3 80000200 0 80000108 00000000 8000010c 0
80000200 1 0 0000000100000002 0 0 00000000 0 80000200 00000002 80000204 0
80000204 99 0 0000000000000000 0 0 00000000 0 80000200 00000002 80000204 1
00000000 0 0 0000000000000000 0 3 80000300 0 80000204 00000000 80000208 0
80000300 7 1 cafef00d00100073 0 0 00000000 2 80000300 00100073 80000304 0
80000304 1 3 0000000000000000 0 0 00000000 0 80000300 00100073 80000304 1
00000000 0 0 0000000000000000 0 3 80000000 0 80000304 00000000 80000308 0
80000000 1 0 1111111100000013 0 0 00000000 0 80000000 00000013 80000004 0

// ==== sim/fetch_unit_chk.sv ====
`timescale 1ns/10ps

module fetch_unit_chk (
	input logic                   clk,
	input logic                   reset,
	input logic                   req,
	input logic                   fault,
	input logic                   capture,
	input logic                   bubble,
	input fetch_pkg::fetch_state_e state
);
	import fetch_pkg::*;

	int fail_cnt = 0;	// read by the testbench summary.

	// one request in flight, so a pulse never lasts two cycles.
	req_pulse: assert property (@(posedge clk) disable iff (reset) req |=> !req)
		else begin
			$error("req stayed high for two consecutive cycles");
			fail_cnt++;
		end

	req_in_fault: assert property (@(posedge clk) disable iff (reset) !(req && fault))
		else begin
			$error("req issued while fault is high");
			fail_cnt++;
		end

	// bubble has priority, both at once means a lost beat.
	cap_bubble: assert property (@(posedge clk) disable iff (reset) !(capture && bubble))
		else begin
			$error("capture and bubble high in the same cycle");
			fail_cnt++;
		end

	req_in_wait: assert property (@(posedge clk) disable iff (reset) (state == s_wait) |-> !req)
		else begin
			$error("req issued while a request is still waiting");
			fail_cnt++;
		end

endmodule

// ==== sim/fetch_unit_tb.sv ====
`timescale 1ns/10ps
`include "fetch_defines.svh"

module fetch_unit_tb;
	import fetch_pkg::*;
	import cpu_bus_pkg::*;

	logic               clk;
	logic               reset;
	logic               id_ready;
	redirect_e          redirect;
	logic [`ADDR_W-1:0] redirect_pc;
	logic               mem_req;
	logic [`ADDR_W-1:0] mem_addr;
	logic               mem_r_valid;
	logic [`BEAT_W-1:0] mem_r_data;
	logic [`ADDR_W-1:0] mem_r_addr;
	mem_resp_e          mem_resp;
	logic               id_valid;
	logic [`ADDR_W-1:0] id_pc;
	logic [`INS_W-1:0]  id_ins;
	logic [`ADDR_W-1:0] id_snpc;
	logic               fault;

	int err_cnt;
	int tmo_cnt;
	int chk_cnt;
	int line_cnt;
	int sva_cnt;
	bit aborted;

	// fields of the current golden line.
	logic [`ADDR_W-1:0] g_addr;
	int                 g_lat;
	logic [1:0]         g_resp;
	logic [`BEAT_W-1:0] g_beat;
	int                 g_rcyc;
	logic [1:0]         g_kind;
	logic [`ADDR_W-1:0] g_target;
	int                 g_rdy_low;
	logic [`ADDR_W-1:0] g_pc;
	logic [`INS_W-1:0]  g_ins;
	logic [`ADDR_W-1:0] g_snpc;
	logic               g_fault;

	fetch_unit fetch_unit_i (
		.clk         (clk),
		.reset       (reset),
		.id_ready    (id_ready),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_r_valid (mem_r_valid),
		.mem_r_data  (mem_r_data),
		.mem_r_addr  (mem_r_addr),
		.mem_resp    (mem_resp),
		.id_valid    (id_valid),
		.id_pc       (id_pc),
		.id_ins      (id_ins),
		.id_snpc     (id_snpc),
		.fault       (fault)
	);

	bind fetch_ctrl fetch_unit_chk fetch_unit_chk_i (
		.clk     (clk),
		.reset   (reset),
		.req     (bus.req),
		.fault   (fault),
		.capture (capture),
		.bubble  (bubble),
		.state   (state)
	);

	always #10 clk = ~clk;	// 20 ns period.

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
			input string what);
		chk_cnt++;
		assert (got === exp) else begin
			$display("[ERROR] %0t %s is %h, expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_outputs(input string tag);
		check_value(id_valid, 1'b1, {tag, " id_valid"});
		check_value(id_pc, g_pc, {tag, " id_pc"});
		check_value(id_ins, g_ins, {tag, " id_ins"});
		check_value(id_snpc, g_snpc, {tag, " id_snpc"});
		check_value(fault, g_fault, {tag, " fault"});
	endtask

	// outputs have settled by the falling edge.
	task automatic next_cycle();
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic wait_for_req();
		int n;
		n = 0;
		while (!mem_req && n < 64) begin
			next_cycle();
			n++;
		end
		if (!mem_req) begin
			$display("timeout: no memory request within 64 cycles at golden line %0d",
				line_cnt);
			tmo_cnt++;
			aborted = 1'b1;
		end
	endtask

	task automatic wait_for_fault();
		int n;
		n = 0;
		while (!fault && n < 64) begin
			next_cycle();
			n++;
		end
		if (!fault) begin
			$display("timeout: fault never rose for the unanswered request at line %0d",
				line_cnt);
			tmo_cnt++;
			aborted = 1'b1;
		end
	endtask

	// first low cycle is the one already sampled.
	task automatic hold_ready_low();
		int k;
		check_value(mem_req, 1'b0, "mem_req under back-pressure");
		for (k = 1; k < g_rdy_low; k++) begin
			next_cycle();
			check_value(mem_req, 1'b0, "mem_req under back-pressure");
			check_outputs("held");
		end
		@(posedge clk);
		id_ready <= 1'b1;
		@(negedge clk);
	endtask

	task automatic run_request();
		int end_t;
		int t;
		wait_for_req();
		if (aborted) begin
			return;
		end
		check_value(mem_addr, g_addr, "mem_addr");
		if (g_rcyc != 0) begin
			end_t = g_rcyc;	// redirect ends the request.
		end else if (g_lat <= `FETCH_TIMEOUT) begin
			end_t = g_lat;
		end else begin
			end_t = `FETCH_TIMEOUT;	// memory stays silent.
		end
		for (t = 1; t <= end_t; t++) begin
			@(posedge clk);
			mem_r_valid <= (t == g_lat);
			mem_r_data  <= g_beat;
			mem_r_addr  <= g_addr;
			mem_resp    <= mem_resp_e'(g_resp);
			redirect    <= (t == g_rcyc) ? redirect_e'(g_kind) : none;
			redirect_pc <= g_target;
		end
		@(posedge clk);
		mem_r_valid <= 1'b0;
		redirect    <= none;
		id_ready    <= (g_rdy_low == 0);
		@(negedge clk);
		if (g_rcyc == 0 && g_lat > `FETCH_TIMEOUT) begin
			// an answer was still allowed up to here.
			check_value(fault, 1'b0, "early fault");
			wait_for_fault();
			if (aborted) begin
				return;
			end
		end
		check_outputs("beat");
		if (g_rdy_low != 0) begin
			hold_ready_low();
		end
	endtask

	// a redirect with no request leaves a fault.
	task automatic run_redirect();
		@(posedge clk);
		redirect    <= redirect_e'(g_kind);
		redirect_pc <= g_target;
		@(posedge clk);
		redirect <= none;
		@(negedge clk);
		check_outputs("redirect");
	endtask

	initial begin
		string line;
		int    fd;
		int    n;
		clk         = 1'b0;
		reset       = 1'b1;
		id_ready    = 1'b1;
		redirect    = none;
		redirect_pc = '0;
		mem_r_valid = 1'b0;
		mem_r_data  = '0;
		mem_r_addr  = '0;
		mem_resp    = okay;
		err_cnt     = 0;
		tmo_cnt     = 0;
		chk_cnt     = 0;
		line_cnt    = 0;
		aborted     = 1'b0;
		repeat (9) @(posedge clk);
		@(negedge clk);
		// outputs stay quiet while reset is held.
		check_value(mem_req, 1'b0, "mem_req in reset");
		check_value(id_valid, 1'b0, "id_valid in reset");
		check_value(fault, 1'b0, "fault in reset");
		@(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		fd = $fopen("sim/fetch_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open the golden file sim/fetch_golden.txt");
			err_cnt++;
		end else begin
			while (!$feof(fd) && !aborted) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 2 || line[0] == "#") begin
					continue;
				end
				n = $sscanf(line, "%h %d %h %h %d %h %h %d %h %h %h %h", g_addr, g_lat,
					g_resp, g_beat, g_rcyc, g_kind, g_target, g_rdy_low, g_pc, g_ins,
					g_snpc, g_fault);
				if (n != 12) begin
					$display("golden line could not be parsed: %s", line);
					err_cnt++;
				end else begin
					line_cnt++;
					if (g_addr == '0) begin
						run_redirect();
					end else begin
						run_request();
					end
				end
			end
			$fclose(fd);
		end
		sva_cnt = fetch_unit_i.fetch_ctrl_i.fetch_unit_chk_i.fail_cnt;
		$display("lines %0d, checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
			line_cnt, chk_cnt, err_cnt, tmo_cnt, sva_cnt);
		if (err_cnt == 0 && tmo_cnt == 0 && sva_cnt == 0 && line_cnt != 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+include
logic/cpu_bus_pkg.sv
logic/fetch_pkg.sv
logic/imem_if.sv
logic/pc_gen.sv
logic/fetch_ctrl.sv
logic/fetch_watchdog.sv
logic/if_stage.sv
logic/fetch_unit.sv
sim/fetch_unit_chk.sv
sim/fetch_unit_tb.sv
